/* design/arb_bist_params.svh */
`ifndef ARB_BIST_PARAMS_SVH
`define ARB_BIST_PARAMS_SVH

// Number of request channels on the arbiter
`define ARB_CHANNELS 4

// Trace word layout, MSB first
//   [11:8] opcode
//   [7:4]  000 + flag (unlock on send, lock on receive)
//   [3:0]  channel vector (requests on send, grants on receive)
`define TRACE_WIDTH 12

// Trace ROM depth is 2**TRACE_ADDR_WIDTH words
`define TRACE_ADDR_WIDTH 6

`endif

/* design/arb_bist_pkg.sv */
`include "arb_bist_params.svh"

package arb_bist_pkg;

        // One bit per requester, bit 3 has the highest priority
        typedef logic [`ARB_CHANNELS-1:0] chan_vec_t;

        // Trace opcodes, one-hot in the top nibble of a trace word
        typedef enum logic [3:0] {
                trace_send   = 4'b0001, // Load requests and unlock
                trace_recv   = 4'b0010, // Compare grants and lock
                trace_finish = 4'b0100  // End of trace
        } trace_op_e;

endpackage

/* design/explicit_trace_rom.sv */
`timescale 1ns/10ps

module explicit_trace_rom #(
        parameter int width_p      = 12,
        parameter int addr_width_p = 6
) (
        input  logic [addr_width_p-1:0] addr_i,
        output logic [width_p-1:0]      data_o
);

        // Send:    0001 000u rrrr  (u = unlock, r = requests)
        // Receive: 0010 000l gggg  (l = lock,   g = grants)
        always_comb begin
                case (addr_i)
                        0:  data_o = width_p'(12'b0001_0000_1111); // All request, ch3 wins
                        1:  data_o = width_p'(12'b0010_0000_1000);
                        2:  data_o = width_p'(12'b0001_0000_0111); // Others blocked by ch3
                        3:  data_o = width_p'(12'b0010_0001_0000);
                        4:  data_o = width_p'(12'b0001_0000_1111); // Locked channel still served
                        5:  data_o = width_p'(12'b0010_0001_1000);
                        6:  data_o = width_p'(12'b0001_0001_1111); // Unlock while granting
                        7:  data_o = width_p'(12'b0010_0001_1000);

                        8:  data_o = width_p'(12'b0001_0000_0111); // Fresh lock on ch2
                        9:  data_o = width_p'(12'b0010_0000_0100);
                        10: data_o = width_p'(12'b0001_0000_0011); // Lower channels blocked
                        11: data_o = width_p'(12'b0010_0001_0000);
                        12: data_o = width_p'(12'b0001_0000_1011); // Higher channel blocked too
                        13: data_o = width_p'(12'b0010_0001_0000);
                        14: data_o = width_p'(12'b0001_0000_0111);
                        15: data_o = width_p'(12'b0010_0001_0100);
                        16: data_o = width_p'(12'b0001_0001_0011); // Release ch2
                        17: data_o = width_p'(12'b0010_0001_0000);

                        18: data_o = width_p'(12'b0001_0000_0011); // Fresh lock on ch1
                        19: data_o = width_p'(12'b0010_0000_0010);
                        20: data_o = width_p'(12'b0001_0000_0001);
                        21: data_o = width_p'(12'b0010_0001_0000);
                        22: data_o = width_p'(12'b0001_0000_1001);
                        23: data_o = width_p'(12'b0010_0001_0000);
                        24: data_o = width_p'(12'b0001_0000_0101);
                        25: data_o = width_p'(12'b0010_0001_0000);
                        26: data_o = width_p'(12'b0001_0000_0011);
                        27: data_o = width_p'(12'b0010_0001_0010);
                        28: data_o = width_p'(12'b0001_0001_0011); // Release ch1 with grant
                        29: data_o = width_p'(12'b0010_0001_0010);

                        30: data_o = width_p'(12'b0001_0000_0001); // Fresh lock on ch0
                        31: data_o = width_p'(12'b0010_0000_0001);
                        32: data_o = width_p'(12'b0001_0000_1000);
                        33: data_o = width_p'(12'b0010_0001_0000);
                        34: data_o = width_p'(12'b0001_0000_0100);
                        35: data_o = width_p'(12'b0010_0001_0000);
                        36: data_o = width_p'(12'b0001_0000_0010);
                        37: data_o = width_p'(12'b0010_0001_0000);
                        38: data_o = width_p'(12'b0001_0000_0001);
                        39: data_o = width_p'(12'b0010_0001_0001);
                        40: data_o = width_p'(12'b0001_0001_0000); // Unlock with no requests
                        41: data_o = width_p'(12'b0010_0001_0000);

                        42: data_o = width_p'(12'b0100_0000_0000); // End of trace
                        default: data_o = '0; // Decodes as an illegal opcode
                endcase
        end

endmodule

/* design/locking_arb_fixed.sv */
`timescale 1ns/10ps
`include "arb_bist_params.svh"

module locking_arb_fixed (
        input  logic                     clk_i,
        input  logic                     rst_n_i,
        input  arb_bist_pkg::chan_vec_t  reqs_i,
        input  logic                     unlock_i,
        output arb_bist_pkg::chan_vec_t  grants_o,
        output logic                     locked_o
);
        import arb_bist_pkg::*;

        logic      lock_q;        // Arbiter is held on one channel
        chan_vec_t locked_chan_q; // One-hot owner of the lock
        chan_vec_t eligible;      // Requests allowed to compete

        // Only the owner may compete while locked
        always_comb begin
                eligible = lock_q ? (reqs_i & locked_chan_q) : reqs_i;
                grants_o = '0;
                for (int i = 0; i < `ARB_CHANNELS; i++) begin
                        if (eligible[i]) begin // Later index overrides, so highest wins
                                grants_o = '0;
                                grants_o[i] = 1'b1;
                        end
                end
        end

        always_ff @(posedge clk_i) begin
                if (!rst_n_i) begin
                        lock_q <= 1'b0;
                end else if (unlock_i) begin
                        lock_q <= 1'b0; // Unlock beats a new lock
                end else if (|grants_o) begin
                        lock_q <= 1'b1;
                end
        end

        always_ff @(posedge clk_i) begin
                if (!unlock_i && (|grants_o)) begin
                        locked_chan_q <= grants_o;
                end
        end

        assign locked_o = lock_q;

endmodule

/* design/trace_replay.sv */
`timescale 1ns/10ps
`include "arb_bist_params.svh"

module trace_replay (
        input  logic                         clk_i,
        input  logic                         rst_n_i,
        input  logic                         start_i,
        output logic [`TRACE_ADDR_WIDTH-1:0] rom_addr_o,
        input  logic [`TRACE_WIDTH-1:0]      rom_data_i,
        output arb_bist_pkg::chan_vec_t      drv_reqs_o,
        output logic                         drv_unlock_o,
        input  arb_bist_pkg::chan_vec_t      arb_grants_i,
        input  logic                         arb_locked_i,
        output logic                         busy_o,
        output logic                         done_o,
        output logic                         fail_o
);
        import arb_bist_pkg::*;

        localparam int op_lsb_lp   = `TRACE_WIDTH - 4; // Opcode nibble
        localparam int flag_pos_lp = `TRACE_WIDTH - 8; // Flag bit of middle nibble

        typedef enum logic [1:0] {
                st_idle,  // After reset, never run
                st_clear, // One unlock cycle ahead of the trace
                st_step,  // One ROM word per cycle
                st_stop   // Run over, done held
        } state_e;

        state_e                        state_q;
        logic [`TRACE_ADDR_WIDTH-1:0]  addr_q;
        logic                          apply_q;  // Drive registers reach the arbiter
        logic                          fail_q;
        chan_vec_t                     reqs_q;
        logic                          unlock_q;
        logic                          start_ok;
        trace_op_e                     op;
        chan_vec_t                     word_vec;
        logic                          word_flag;
        logic                          mismatch;

        // Split the current ROM word
        always_comb begin
                op        = trace_op_e'(rom_data_i[op_lsb_lp +: 4]);
                word_vec  = rom_data_i[`ARB_CHANNELS-1:0];
                word_flag = rom_data_i[flag_pos_lp];
                mismatch  = (arb_grants_i != word_vec) || (arb_locked_i != word_flag);
        end

        assign start_ok = start_i && ((state_q == st_idle) || (state_q == st_stop));

        always_ff @(posedge clk_i) begin
                if (!rst_n_i) begin
                        state_q <= st_idle;
                        addr_q  <= '0;
                        apply_q <= 1'b0;
                        fail_q  <= 1'b0;
                end else begin
                        case (state_q)
                                st_idle, st_stop: begin
                                        if (start_ok) begin
                                                state_q <= st_clear;
                                                apply_q <= 1'b1; // Clearing cycle
                                                fail_q  <= 1'b0;
                                        end
                                        addr_q <= '0;
                                end
                                st_clear: begin
                                        state_q <= st_step;
                                        apply_q <= 1'b0;
                                        addr_q  <= '0;
                                end
                                st_step: begin
                                        addr_q  <= addr_q + 1'b1;
                                        apply_q <= 1'b0;
                                        case (op)
                                                trace_send: apply_q <= 1'b1;
                                                trace_recv: begin
                                                        if (mismatch) begin
                                                                fail_q <= 1'b1;
                                                        end
                                                end
                                                trace_finish: state_q <= st_stop;
                                                default: begin // Bad opcode ends run
                                                        fail_q  <= 1'b1;
                                                        state_q <= st_stop;
                                                end
                                        endcase
                                end
                                default: state_q <= st_idle;
                        endcase
                end
        end

        // Drive values, held for the receive cycle
        always_ff @(posedge clk_i) begin
                if (start_ok) begin
                        reqs_q   <= '0;
                        unlock_q <= 1'b1;
                end else if ((state_q == st_step) && (op == trace_send)) begin
                        reqs_q   <= word_vec;
                        unlock_q <= word_flag;
                end
        end

        assign rom_addr_o   = addr_q;
        assign drv_reqs_o   = apply_q ? reqs_q : '0;
        assign drv_unlock_o = apply_q & unlock_q;
        assign busy_o       = (state_q == st_clear) || (state_q == st_step);
        assign done_o       = (state_q == st_stop);
        assign fail_o       = fail_q;

endmodule

/* design/arb_bist_top.sv */
`timescale 1ns/10ps
`include "arb_bist_params.svh"

module arb_bist_top (
        input  logic                     clk_i,
        input  logic                     rst_n_i,
        input  arb_bist_pkg::chan_vec_t  reqs_i,
        input  logic                     unlock_i,
        input  logic                     bist_start_i,
        output arb_bist_pkg::chan_vec_t  grants_o,
        output logic                     locked_o,
        output logic                     bist_busy_o,
        output logic                     bist_done_o,
        output logic                     bist_fail_o
);
        import arb_bist_pkg::*;

        logic [`TRACE_ADDR_WIDTH-1:0] rom_addr;
        logic [`TRACE_WIDTH-1:0]      rom_data;
        chan_vec_t                    drv_reqs;
        logic                         drv_unlock;
        chan_vec_t                    arb_reqs;
        logic                         arb_unlock;

        explicit_trace_rom #(
                .width_p      (`TRACE_WIDTH),
                .addr_width_p (`TRACE_ADDR_WIDTH)
        ) rom (
                .addr_i (rom_addr),
                .data_o (rom_data)
        );

        trace_replay replay (
                .clk_i        (clk_i),
                .rst_n_i      (rst_n_i),
                .start_i      (bist_start_i),
                .rom_addr_o   (rom_addr),
                .rom_data_i   (rom_data),
                .drv_reqs_o   (drv_reqs),
                .drv_unlock_o (drv_unlock),
                .arb_grants_i (grants_o),
                .arb_locked_i (locked_o),
                .busy_o       (bist_busy_o),
                .done_o       (bist_done_o),
                .fail_o       (bist_fail_o)
        );

        // BIST owns the arbiter inputs for the whole run
        always_comb begin
                if (bist_busy_o) begin
                        arb_reqs   = drv_reqs;
                        arb_unlock = drv_unlock;
                end else begin
                        arb_reqs   = reqs_i;
                        arb_unlock = unlock_i;
                end
        end

        locking_arb_fixed arb (
                .clk_i    (clk_i),
                .rst_n_i  (rst_n_i),
                .reqs_i   (arb_reqs),
                .unlock_i (arb_unlock),
                .grants_o (grants_o),
                .locked_o (locked_o)
        );

endmodule

/* tb/arb_bist_tb.sv */
`timescale 1ns/10ps
`include "arb_bist_params.svh"

module arb_bist_tb;
        import arb_bist_pkg::*;

        localparam int bist_timeout_lp = 200; // Cycles allowed for one BIST run

        logic      clk;
        logic      rst_n;
        chan_vec_t reqs;
        logic      unlock;
        logic      bist_start;
        chan_vec_t grants;
        logic      locked;
        logic      bist_busy;
        logic      bist_done;
        logic      bist_fail;

        integer    seed;
        logic      model_lock;  // Reference lock flag
        chan_vec_t model_chan;  // Reference one-hot lock owner
        chan_vec_t seen_grants; // Outputs sampled mid-cycle
        logic      seen_locked;
        logic      seen_busy;
        logic      seen_done;
        logic      seen_fail;

        arb_bist_top dut (
                .clk_i        (clk),
                .rst_n_i      (rst_n),
                .reqs_i       (reqs),
                .unlock_i     (unlock),
                .bist_start_i (bist_start),
                .grants_o     (grants),
                .locked_o     (locked),
                .bist_busy_o  (bist_busy),
                .bist_done_o  (bist_done),
                .bist_fail_o  (bist_fail)
        );

        initial begin
                clk = 1'b0;
                forever #10 clk = ~clk;
        end

        // Highest index among the requests allowed by the lock
        function automatic chan_vec_t expected_grant(input chan_vec_t req_vec);
                chan_vec_t eligible;
                chan_vec_t pick;
                eligible = model_lock ? (req_vec & model_chan) : req_vec;
                pick     = '0;
                for (int i = `ARB_CHANNELS - 1; i >= 0; i--) begin
                        if (eligible[i] && (pick == '0)) begin
                                pick[i] = 1'b1;
                        end
                end
                return pick;
        endfunction

        task automatic check_grants(input string name, input chan_vec_t got,
                                    input chan_vec_t exp);
                if (got !== exp) begin
                        $display("Error at %0t: %s is %b, expected %b", $time, name, got, exp);
                        $display("Simulation finished: FAIL");
                        $fatal(1, "Grant vector mismatch");
                end
        endtask

        task automatic check_flag(input string name, input logic got, input logic exp);
                if (got !== exp) begin
                        $display("Error at %0t: %s is %b, expected %b", $time, name, got, exp);
                        $display("Simulation finished: FAIL");
                        $fatal(1, "Flag mismatch");
                end
        endtask

        task automatic stop_on_timeout(input string what);
                $display("Timeout at %0t: %s", $time, what);
                $display("Simulation finished: FAIL");
                $fatal(1, "Wait timed out");
        endtask

        // Drive on the falling edge, check mid-cycle, advance model at the rising edge
        task automatic run_cycle(input chan_vec_t req_vec, input logic unl, input logic start);
                chan_vec_t exp_grants;
                @(negedge clk);
                reqs       = req_vec;
                unlock     = unl;
                bist_start = start;
                #1;
                seen_grants = grants;
                seen_locked = locked;
                seen_busy   = bist_busy;
                seen_done   = bist_done;
                seen_fail   = bist_fail;
                exp_grants  = expected_grant(req_vec);
                if (!seen_busy) begin // Functional mode only
                        check_grants("grants_o", seen_grants, exp_grants);
                        check_flag("locked_o", seen_locked, model_lock);
                end
                @(posedge clk);
                if (seen_busy) begin
                        model_lock = 1'b0; // Trace opens and closes with an unlock
                end else if (unl) begin
                        model_lock = 1'b0; // Unlock beats a new lock
                end else if (exp_grants != '0) begin
                        model_lock = 1'b1;
                        model_chan = exp_grants;
                end
        endtask

        // Random functional traffic, unlock about one cycle in eight
        task automatic random_traffic(input int cycles, input logic bist_ran);
                int rnd;
                for (int n = 0; n < cycles; n++) begin
                        rnd = $random(seed);
                        run_cycle(rnd[`ARB_CHANNELS-1:0], (rnd[6:4] == 3'b000), 1'b0);
                        check_flag("bist_busy_o", seen_busy, 1'b0);
                        check_flag("bist_done_o", seen_done, bist_ran); // Done holds
                        check_flag("bist_fail_o", seen_fail, 1'b0);
                end
        endtask

        // Start pulse, then random requests on the ignored inputs until done
        task automatic run_bist();
                int rnd;
                int wait_cnt;
                rnd = $random(seed);
                run_cycle(rnd[`ARB_CHANNELS-1:0], 1'b0, 1'b1);
                rnd = $random(seed);
                run_cycle(rnd[`ARB_CHANNELS-1:0], rnd[4], 1'b0);
                check_flag("bist_busy_o", seen_busy, 1'b1);
                check_flag("bist_done_o", seen_done, 1'b0); // Start clears done
                check_flag("bist_fail_o", seen_fail, 1'b0);
                wait_cnt = 0;
                while (!seen_done && (wait_cnt < bist_timeout_lp)) begin
                        rnd = $random(seed);
                        run_cycle(rnd[`ARB_CHANNELS-1:0], rnd[4], 1'b0);
                        wait_cnt++;
                end
                if (!seen_done) begin
                        stop_on_timeout("bist_done_o never rose after the start pulse");
                end
                check_flag("bist_busy_o", seen_busy, 1'b0);
                check_flag("bist_fail_o", seen_fail, 1'b0);
        endtask

        initial begin
                int rnd;
                seed        = 32'he5e4;
                rst_n       = 1'b0;
                reqs        = '0;
                unlock      = 1'b0;
                bist_start  = 1'b0;
                model_lock  = 1'b0;
                model_chan  = '0;
                seen_grants = '0;
                seen_locked = 1'b0;
                seen_busy   = 1'b0;
                seen_done   = 1'b0;
                seen_fail   = 1'b0;
                repeat (5) @(posedge clk);
                @(negedge clk);
                rst_n = 1'b1;

                run_cycle('0, 1'b0, 1'b0); // Reset state
                check_flag("bist_busy_o", seen_busy, 1'b0);
                check_flag("bist_done_o", seen_done, 1'b0);
                check_flag("bist_fail_o", seen_fail, 1'b0);

                // Plain priority, unlock every cycle
                for (int n = 0; n < 64; n++) begin
                        rnd = $random(seed);
                        run_cycle(rnd[`ARB_CHANNELS-1:0], 1'b1, 1'b0);
                        check_flag("locked_o", seen_locked, 1'b0);
                end

                random_traffic(200, 1'b0); // Lock hold and blocking

                // Unlock in the same cycle as a grant
                run_cycle('0, 1'b1, 1'b0);
                run_cycle(4'b0100, 1'b1, 1'b0);
                check_grants("grants_o", seen_grants, 4'b0100);
                run_cycle('0, 1'b0, 1'b0);
                check_flag("locked_o", seen_locked, 1'b0);

                // Owner granted while unlocking its own lock
                run_cycle(4'b0010, 1'b0, 1'b0);
                run_cycle(4'b1010, 1'b1, 1'b0);
                check_grants("grants_o", seen_grants, 4'b0010);
                check_flag("locked_o", seen_locked, 1'b1);
                run_cycle('0, 1'b0, 1'b0);
                check_flag("locked_o", seen_locked, 1'b0);

                // Leave a live lock ahead of the BIST run
                run_cycle(4'b1000, 1'b0, 1'b0);
                run_cycle('0, 1'b0, 1'b0);
                check_flag("locked_o", seen_locked, 1'b1);

                run_bist();
                random_traffic(40, 1'b1);

                run_bist(); // Rerun from the stop state
                random_traffic(100, 1'b1);

                $display("Simulation finished: PASS");
                $finish;
        end

endmodule

/* arb_bist_top.f */
+incdir+design
design/arb_bist_pkg.sv
design/explicit_trace_rom.sv
design/locking_arb_fixed.sv
design/trace_replay.sv
design/arb_bist_top.sv
tb/arb_bist_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build the arbiter BIST testbench with Verilator and run it.
# The exit status is the simulator's, nonzero when the testbench stops with $fatal.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal \
        --top-module arb_bist_tb \
        -f arb_bist_top.f \
        -o arb_bist_sim \
        && ./obj_dir/arb_bist_sim \
        || { echo "Build or simulation failed"; exit 1; }

exit 0
